/* verilog/imuldiv_pkg.sv */
/* shared widths, codes and message structs for the mul/div unit
   all operations are signed 32-bit, responses are 64 bits with a tag */

package imuldiv_pkg;

  // --------------------------------------------------
  // widths and step counts
  // --------------------------------------------------
  localparam int unsigned data_width   = 32;
  localparam int unsigned result_width = 64;
  localparam int unsigned tag_width    = 4;
  localparam int unsigned step_count   = 32;
  localparam int unsigned count_width  = $clog2(step_count);

  // counter value on the final iteration step
  localparam logic [count_width-1:0] last_step = count_width'(step_count - 1);

  // function codes
  localparam logic fn_mul = 1'b0;
  localparam logic fn_div = 1'b1;

  // --------------------------------------------------
  // messages
  // --------------------------------------------------
  typedef struct packed {
    logic                  fn;
    logic [tag_width-1:0]  tag;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } muldiv_req_t;

  typedef struct packed {
    logic [tag_width-1:0]    tag;
    logic [result_width-1:0] result;
  } muldiv_resp_t;

  // iterative peer control states
  typedef enum logic [1:0] {st_idle, st_calc, st_done} peer_state_t;

endpackage

/* verilog/imuldiv_dispatch.sv */
/* one-entry request buffer in front of the two peers
   a request for a busy peer stalls here even if the other peer is idle */

module imuldiv_dispatch (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imuldiv_pkg::muldiv_req_t req_msg,
  output logic                     mul_req_val,
  input  logic                     mul_req_rdy,
  output logic                     div_req_val,
  input  logic                     div_req_rdy,
  output imuldiv_pkg::muldiv_req_t req_out
);

  logic                     buf_val;
  imuldiv_pkg::muldiv_req_t buf_msg;
  logic                     sel_rdy;
  logic                     drain;
  logic                     accept;

  // ready of whichever peer the buffered fn points at
  assign sel_rdy = (buf_msg.fn == imuldiv_pkg::fn_div) ? div_req_rdy : mul_req_rdy;

  // entry leaves when the selected peer takes it
  assign drain  = buf_val && sel_rdy;

  // free slot, or slot being emptied this cycle
  assign req_rdy = !buf_val || drain;
  assign accept  = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_val <= 1'b0;
    end else if (accept) begin
      buf_val <= 1'b1;
    end else if (drain) begin
      buf_val <= 1'b0;
    end
  end

  // payload only moves on a top-level handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_msg <= req_msg;
    end
  end

  // only the matching peer sees a valid request
  assign mul_req_val = buf_val && (buf_msg.fn == imuldiv_pkg::fn_mul);
  assign div_req_val = buf_val && (buf_msg.fn == imuldiv_pkg::fn_div);
  assign req_out     = buf_msg;

endmodule

/* verilog/imuldiv_mul_iterative.sv */
/* 32-step signed shift-and-add multiplier, one operation at a time
   works on magnitudes and fixes the sign on the way out */

module imuldiv_mul_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::muldiv_resp_t resp_msg
);

  imuldiv_pkg::peer_state_t               state;
  logic [imuldiv_pkg::count_width-1:0]    count;
  logic [imuldiv_pkg::result_width-1:0]   a_reg;
  logic [imuldiv_pkg::data_width-1:0]     b_reg;
  logic [imuldiv_pkg::result_width-1:0]   acc_reg;
  logic                                   neg_reg;
  logic [imuldiv_pkg::tag_width-1:0]      tag_reg;
  logic                                   a_neg;
  logic                                   b_neg;
  logic [imuldiv_pkg::data_width-1:0]     a_mag;
  logic [imuldiv_pkg::data_width-1:0]     b_mag;
  logic                                   req_fire;
  logic                                   resp_fire;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  assign req_rdy   = (state == imuldiv_pkg::st_idle);
  assign resp_val  = (state == imuldiv_pkg::st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          if (req_fire) begin
            state <= imuldiv_pkg::st_calc;
            count <= '0;
          end
        end
        imuldiv_pkg::st_calc: begin
          // exactly step_count cycles in here
          if (count == imuldiv_pkg::last_step) begin
            state <= imuldiv_pkg::st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        imuldiv_pkg::st_done: begin
          // result held until the arbiter takes it
          if (resp_fire) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  assign a_neg = req_msg.a[imuldiv_pkg::data_width-1];
  assign b_neg = req_msg.b[imuldiv_pkg::data_width-1];
  // most negative input maps to 2^31, still exact as unsigned
  assign a_mag = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag = b_neg ? -req_msg.b : req_msg.b;

  always_ff @(posedge clk) begin
    if (req_fire) begin
      a_reg   <= {{imuldiv_pkg::data_width{1'b0}}, a_mag};
      b_reg   <= b_mag;
      acc_reg <= '0;
      // sign and tag latched here, request may change afterwards
      neg_reg <= a_neg ^ b_neg;
      tag_reg <= req_msg.tag;
    end else if (state == imuldiv_pkg::st_calc) begin
      // add partial product when multiplier bit is set
      if (b_reg[0]) begin
        acc_reg <= acc_reg + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // negate the magnitude product for mixed signs
  always_comb begin
    resp_msg.tag    = tag_reg;
    resp_msg.result = neg_reg ? -acc_reg : acc_reg;
  end

endmodule

/* verilog/imuldiv_div_iterative.sv */
/* 32-step signed restoring divider, one operation at a time
   quotient truncates toward zero, remainder follows the dividend sign
   divide by zero gives all-ones quotient and the dividend as remainder */

module imuldiv_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::muldiv_resp_t resp_msg
);

  imuldiv_pkg::peer_state_t               state;
  logic [imuldiv_pkg::count_width-1:0]    count;
  logic [imuldiv_pkg::result_width-1:0]   rq_reg;
  logic [imuldiv_pkg::data_width-1:0]     dvsr_reg;
  logic                                   q_neg_reg;
  logic                                   r_neg_reg;
  logic                                   zero_reg;
  logic [imuldiv_pkg::tag_width-1:0]      tag_reg;
  logic                                   a_neg;
  logic                                   b_neg;
  logic [imuldiv_pkg::data_width-1:0]     a_mag;
  logic [imuldiv_pkg::data_width-1:0]     b_mag;
  logic [imuldiv_pkg::result_width-1:0]   rq_shift;
  logic [imuldiv_pkg::data_width:0]       diff;
  logic [imuldiv_pkg::data_width-1:0]     q_mag;
  logic [imuldiv_pkg::data_width-1:0]     r_mag;
  logic [imuldiv_pkg::data_width-1:0]     quo;
  logic [imuldiv_pkg::data_width-1:0]     rem;
  logic                                   req_fire;
  logic                                   resp_fire;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  assign req_rdy   = (state == imuldiv_pkg::st_idle);
  assign resp_val  = (state == imuldiv_pkg::st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          if (req_fire) begin
            state <= imuldiv_pkg::st_calc;
            count <= '0;
          end
        end
        imuldiv_pkg::st_calc: begin
          if (count == imuldiv_pkg::last_step) begin
            state <= imuldiv_pkg::st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        imuldiv_pkg::st_done: begin
          if (resp_fire) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  assign a_neg = req_msg.a[imuldiv_pkg::data_width-1];
  assign b_neg = req_msg.b[imuldiv_pkg::data_width-1];
  assign a_mag = a_neg ? -req_msg.a : req_msg.a;
  assign b_mag = b_neg ? -req_msg.b : req_msg.b;

  // upper half is the partial remainder, lower half dividend then quotient
  assign rq_shift = rq_reg << 1;
  // trial subtract, top bit set means it went negative
  assign diff = {1'b0, rq_shift[imuldiv_pkg::result_width-1:imuldiv_pkg::data_width]}
              - {1'b0, dvsr_reg};

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rq_reg    <= {{imuldiv_pkg::data_width{1'b0}}, a_mag};
      dvsr_reg  <= b_mag;
      q_neg_reg <= a_neg ^ b_neg;
      r_neg_reg <= a_neg;
      zero_reg  <= (req_msg.b == '0);
      tag_reg   <= req_msg.tag;
    end else if (state == imuldiv_pkg::st_calc) begin
      if (!diff[imuldiv_pkg::data_width]) begin
        // subtraction fits, keep it and set quotient bit
        rq_reg <= {diff[imuldiv_pkg::data_width-1:0],
                   rq_shift[imuldiv_pkg::data_width-1:1], 1'b1};
      end else begin
        // restore, quotient bit stays zero
        rq_reg <= rq_shift;
      end
    end
  end

  // --------------------------------------------------
  // output sign fix
  // --------------------------------------------------
  assign q_mag = rq_reg[imuldiv_pkg::data_width-1:0];
  assign r_mag = rq_reg[imuldiv_pkg::result_width-1:imuldiv_pkg::data_width];

  // zero divisor leaves |a| as remainder, so only the quotient needs an override
  // min / -1 falls out naturally as 2^31 with positive sign
  assign quo = zero_reg ? '1 : (q_neg_reg ? -q_mag : q_mag);
  assign rem = r_neg_reg ? -r_mag : r_mag;

  always_comb begin
    resp_msg.tag    = tag_reg;
    resp_msg.result = {rem, quo};
  end

endmodule

/* verilog/imuldiv_resp_arbiter.sv */
/* two-way round-robin onto the shared response port
   val and msg pass through combinationally, grant history moves on handshake */

module imuldiv_resp_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      mul_resp_val,
  output logic                      mul_resp_rdy,
  input  imuldiv_pkg::muldiv_resp_t mul_resp_msg,
  input  logic                      div_resp_val,
  output logic                      div_resp_rdy,
  input  imuldiv_pkg::muldiv_resp_t div_resp_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::muldiv_resp_t resp_msg
);

  // last_div set means the divider won the previous handshake
  logic last_div;
  logic grant_div;
  logic resp_fire;

  // --------------------------------------------------
  // grant
  // --------------------------------------------------
  // divider wins when alone, or on a tie when the multiplier went last
  assign grant_div = div_resp_val && (!mul_resp_val || !last_div);

  assign resp_val = mul_resp_val || div_resp_val;
  assign resp_msg = grant_div ? div_resp_msg : mul_resp_msg;

  // only the granted peer sees ready
  assign mul_resp_rdy = resp_rdy && !grant_div;
  assign div_resp_rdy = resp_rdy && grant_div;

  assign resp_fire = resp_val && resp_rdy;

  // --------------------------------------------------
  // grant history
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      last_div <= 1'b0;
    end else if (resp_fire) begin
      last_div <= grant_div;
    end
  end

endmodule

/* verilog/imuldiv_top.sv */
/* signed mul/div unit, dispatcher plus two iterative peers and an arbiter
   idle latency is 34 cycles from request handshake to resp_val */

module imuldiv_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::muldiv_req_t  req_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output imuldiv_pkg::muldiv_resp_t resp_msg
);

  // dispatcher to peers
  logic                      mul_req_val;
  logic                      mul_req_rdy;
  logic                      div_req_val;
  logic                      div_req_rdy;
  imuldiv_pkg::muldiv_req_t  peer_req;

  // peers to arbiter
  logic                      mul_resp_val;
  logic                      mul_resp_rdy;
  imuldiv_pkg::muldiv_resp_t mul_resp_msg;
  logic                      div_resp_val;
  logic                      div_resp_rdy;
  imuldiv_pkg::muldiv_resp_t div_resp_msg;

  imuldiv_dispatch dispatch (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_msg     (req_msg),
    .mul_req_val (mul_req_val),
    .mul_req_rdy (mul_req_rdy),
    .div_req_val (div_req_val),
    .div_req_rdy (div_req_rdy),
    .req_out     (peer_req)
  );

  imuldiv_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (peer_req),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp_msg)
  );

  imuldiv_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (peer_req),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp_msg)
  );

  imuldiv_resp_arbiter arb (
    .clk          (clk),
    .reset        (reset),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp_msg (mul_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_resp_msg (div_resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_msg     (resp_msg)
  );

endmodule

/* tests/imuldiv_tb.sv */
/* directed tests for the mul/div unit with responses matched by tag
   at most 16 requests may be outstanding and every wait gives up after 200 cycles */

module imuldiv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 200;

  logic                      clk;
  logic                      reset;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::muldiv_req_t  req_msg;
  logic                      resp_val;
  logic                      resp_rdy;
  imuldiv_pkg::muldiv_resp_t resp_msg;

  int          errors;
  int          checks;
  integer      seed;
  logic [3:0]  next_tag;
  // expected result per tag, and whether that tag is still in flight
  logic [63:0] expected [16];
  logic        pending [16];

  imuldiv_top DUT (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [63:0] model_result(input logic fn, input logic [31:0] a,
                                               input logic [31:0] b);
    longint     sa;
    longint     sb;
    logic [31:0] q;
    logic [31:0] r;
    sa = $signed(a);
    sb = $signed(b);
    if (fn == imuldiv_pkg::fn_mul) begin
      return sa * sb;
    end
    if (b == 32'd0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = 32'd0;
    end else begin
      // integer division truncates toward zero and the remainder follows the dividend
      q = 32'(sa / sb);
      r = 32'(sa % sb);
    end
    return {r, q};
  endfunction

  // --------------------------------------------------
  // handshake helpers that start and end on a rising edge
  // --------------------------------------------------
  task automatic send(input logic fn, input logic [3:0] tag, input logic [31:0] a,
                      input logic [31:0] b);
    imuldiv_pkg::muldiv_req_t msg;
    int                       waited;
    msg.fn  = fn;
    msg.tag = tag;
    msg.a   = a;
    msg.b   = b;
    waited  = 0;
    req_val <= 1'b1;
    req_msg <= msg;
    do begin
      @(posedge clk);
      waited++;
    end while (!req_rdy && waited < timeout_cycles);
    if (!req_rdy) begin
      $display("timeout: req_rdy stayed low for tag %0d", tag);
      errors++;
    end
    req_val <= 1'b0;
  endtask

  task automatic collect(output logic ok, output logic [3:0] tag,
                         output logic [63:0] result, output int waited);
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!(resp_val && resp_rdy) && waited < timeout_cycles);
    ok     = resp_val && resp_rdy;
    tag    = resp_msg.tag;
    result = resp_msg.result;
    if (!ok) begin
      $display("timeout: no response within %0d cycles", waited);
      errors++;
    end
  endtask

  // send with a fresh tag and remember what should come back
  task automatic issue(input logic fn, input logic [31:0] a, input logic [31:0] b);
    expected[next_tag] = model_result(fn, a, b);
    pending[next_tag]  = 1'b1;
    send(fn, next_tag, a, b);
    next_tag++;
  endtask

  // take one response and check it against its tag
  task automatic retire(output int waited);
    logic        ok;
    logic [3:0]  tag;
    logic [63:0] result;
    collect(ok, tag, result, waited);
    if (ok) begin
      checks++;
      if (!pending[tag]) begin
        $display("Error at %0t: response tag %0d matches no request in flight", $time, tag);
        errors++;
      end else if (result !== expected[tag]) begin
        $display("Error at %0t: tag %0d result %h, expected %h", $time, tag, result,
                 expected[tag]);
        errors++;
      end
      pending[tag] = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic multiply_corners_random();
    logic [31:0] vals [5] = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    int          waited;
    // every pairing covers mixed signs and both extremes
    foreach (vals[i]) begin
      foreach (vals[j]) begin
        issue(imuldiv_pkg::fn_mul, vals[i], vals[j]);
        retire(waited);
      end
    end
    repeat (20) begin
      issue(imuldiv_pkg::fn_mul, $random(seed), $random(seed));
      retire(waited);
    end
  endtask

  task automatic divide_signs();
    int dv_a [6] = '{7, -7, 7, -7, 100, -2147483647};
    int dv_b [6] = '{2, 2, -2, -2, -7, 3};
    int waited;
    foreach (dv_a[i]) begin
      issue(imuldiv_pkg::fn_div, dv_a[i], dv_b[i]);
      retire(waited);
    end
    // small divisors keep quotient and remainder both interesting
    repeat (20) begin
      issue(imuldiv_pkg::fn_div, $random(seed), $random(seed) % 65536);
      retire(waited);
    end
  endtask

  task automatic divide_corners();
    int waited;
    issue(imuldiv_pkg::fn_div, 32'd5, 32'd0);
    retire(waited);
    issue(imuldiv_pkg::fn_div, 32'hffff_fffb, 32'd0);
    retire(waited);
    issue(imuldiv_pkg::fn_div, 32'h8000_0000, 32'd0);
    retire(waited);
    issue(imuldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    retire(waited);
  endtask

  task automatic overlap_mul_div();
    int waited;
    issue(imuldiv_pkg::fn_mul, 32'h1234_5678, 32'hfedc_ba98);
    issue(imuldiv_pkg::fn_div, 32'h8765_4321, 32'd1234);
    retire(waited);
    retire(waited);
  endtask

  task automatic hold_responses();
    int waited;
    resp_rdy <= 1'b0;
    issue(imuldiv_pkg::fn_mul, 32'hffff_fff9, 32'd13);
    issue(imuldiv_pkg::fn_div, 32'd1000, 32'hffff_fffd);
    // third request parks in the buffer behind the busy multiplier
    issue(imuldiv_pkg::fn_mul, 32'd6, 32'd7);
    repeat (2) @(posedge clk);
    checks++;
    if (req_rdy) begin
      $display("Error at %0t: req_rdy high with the dispatch buffer full", $time);
      errors++;
    end
    repeat (60) @(posedge clk);
    checks++;
    if (!resp_val) begin
      $display("Error at %0t: resp_val low with finished peers held", $time);
      errors++;
    end
    resp_rdy <= 1'b1;
    repeat (3) retire(waited);
  endtask

  task automatic idle_latency();
    int waited;
    issue(imuldiv_pkg::fn_div, 32'd99, 32'd4);
    retire(waited);
    checks++;
    if (waited != 34) begin
      $display("Error at %0t: latency %0d cycles, expected 34", $time, waited);
      errors++;
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_msg  = '0;
    resp_rdy = 1'b1;
    errors   = 0;
    checks   = 0;
    seed     = 28874;
    next_tag = '0;
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    checks++;
    if (!req_rdy || resp_val) begin
      $display("Error at %0t: wrong handshake state after reset", $time);
      errors++;
    end
    multiply_corners_random();
    divide_signs();
    divide_corners();
    overlap_mul_div();
    hold_responses();
    idle_latency();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/imuldiv_pkg.sv
verilog/imuldiv_dispatch.sv
verilog/imuldiv_mul_iterative.sv
verilog/imuldiv_div_iterative.sv
verilog/imuldiv_resp_arbiter.sv
verilog/imuldiv_top.sv
tests/imuldiv_tb.sv
